// ==== filelist.f ====
+incdir+include
verilog/vec_pkg.sv
verilog/vec_csr.sv
verilog/vec_sequencer.sv
verilog/vec_regbank.sv
verilog/vec_alu.sv
verilog/vec_lsu.sv
verilog/vec_unit.sv
dv/vec_unit_assert.sv
dv/vec_unit_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator and run the vec_unit testbench from the project root
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -f filelist.f --top-module vec_unit_tb \
    -o vec_unit_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/vec_unit_sim > sim.log 2>&1 || true
cat sim.log
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// ==== dv/vec_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_unit_tb import vec_pkg::*; ();

    localparam int MEM_WORDS      = 64;
    localparam int TIMEOUT_CYCLES = 200;

    logic                       clk, reset_n, cmd_req, cmd_ack, mem_rd_en;
    vec_cmd_t                   cmd;
    logic [`VEC_XLEN-1:0]       res, mem_addr, mem_wdata, mem_rdata;
    logic [`VEC_XLEN/8-1:0]     mem_we;

    logic [31:0]                mem [MEM_WORDS];
    logic [31:0]                ref_mem [MEM_WORDS];
    logic [`VEC_VLEN-1:0]       ref_regs [`VEC_NREGS];
    int                         ref_ewb, ref_nregs, ref_vl;

    vec_cmd_t                   cmd_list [$];
    logic [31:0]                exp_list [$];
    int                         value_errors, timeout_errors;
    integer                     seed;
    bit                         handshake_ok;

    vec_unit vec_unit_inst (
        .clk(clk), .reset_n(reset_n), .cmd_req_i(cmd_req), .cmd_i(cmd),
        .cmd_ack_o(cmd_ack), .res_o(res), .mem_addr_o(mem_addr),
        .mem_rd_en_o(mem_rd_en), .mem_we_o(mem_we), .mem_wdata_o(mem_wdata),
        .mem_rdata_i(mem_rdata)
    );

    bind vec_unit vec_unit_assert vec_unit_assert_inst (
        .clk(clk), .reset_n(reset_n), .cmd_req_i(cmd_req_i), .cmd_i(cmd_i),
        .cmd_ack_o(cmd_ack_o), .mem_rd_en_o(mem_rd_en_o), .mem_we_o(mem_we_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Synchronous read, byte-strobed write
    always @(posedge clk) begin
        if (mem_rd_en) begin
            mem_rdata <= mem[mem_addr[7:2]];
        end
        for (int b = 0; b < 4; b++) begin
            if (mem_we[b]) begin
                mem[mem_addr[7:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Reference model of the vector unit

    function automatic logic [31:0] model_command(input vec_cmd_t c);
        int             ewb, epr, nregs, vlmax, w, addr;
        logic [63:0]    mask, a, b, lane, dst;
        logic [4:0]     rg;
        logic [31:0]    exp_res;
        exp_res = '0;
        ewb     = ref_ewb;
        epr     = 8 / ewb;
        nregs   = ref_nregs;
        w       = 8 * ewb;
        mask    = (64'd1 << w) - 64'd1;
        case (c.op)
            VSETVL: begin
                // Element width in bytes and registers per group
                case (c.sew)
                    EW8:     ref_ewb = 1;
                    EW16:    ref_ewb = 2;
                    default: ref_ewb = 4;
                endcase
                case (c.lmul)
                    LMUL_1:  ref_nregs = 1;
                    LMUL_2:  ref_nregs = 2;
                    default: ref_nregs = 4;
                endcase
                vlmax    = (8 / ref_ewb) * ref_nregs;
                ref_vl   = (c.scalar < 32'(vlmax)) ? int'(c.scalar) : vlmax;
                exp_res  = 32'(ref_vl);
            end
            VMV_X_S: begin
                exp_res = 32'(ref_regs[c.vs2] & mask);
            end
            VLE, VSE: begin
                for (int r = 0; r < nregs; r++) begin
                    rg = c.vd + 5'(r);
                    for (int k = 0; k < 8; k++) begin
                        addr = int'(c.scalar) + 8 * r + k;
                        // Bytes of tail elements are left alone
                        if (r * epr + k / ewb < ref_vl) begin
                            if (c.op == VLE) begin
                                ref_regs[rg][8*k +: 8] = ref_mem[6'(addr / 4)][8*(addr % 4) +: 8];
                            end else begin
                                ref_mem[6'(addr / 4)][8*(addr % 4) +: 8] = ref_regs[rg][8*k +: 8];
                            end
                        end
                    end
                end
            end
            default: begin
                for (int r = 0; r < nregs; r++) begin
                    dst = ref_regs[c.vd + 5'(r)];
                    for (int e = 0; e < epr; e++) begin
                        a = (ref_regs[c.vs2 + 5'(r)] >> (w * e)) & mask;
                        b = (ref_regs[c.vs1 + 5'(r)] >> (w * e)) & mask;
                        if (c.op == VADD_VX) begin
                            b = 64'(c.scalar) & mask;
                        end
                        case (c.op)
                            VSUB_VV: lane = a - b;
                            VAND_VV: lane = a & b;
                            VOR_VV:  lane = a | b;
                            VXOR_VV: lane = a ^ b;
                            default: lane = a + b;
                        endcase
                        if (r * epr + e < ref_vl) begin
                            dst = (dst & ~(mask << (w * e))) | ((lane & mask) << (w * e));
                        end
                    end
                    ref_regs[c.vd + 5'(r)] = dst;
                end
            end
        endcase
        return exp_res;
    endfunction

    ////////////////////////////////////////////////////////////
    // Command table

    task automatic enqueue(input vec_cmd_t c);
        cmd_list.push_back(c);
        exp_list.push_back(model_command(c));
    endtask

    task automatic setvl_row(input vew_e sew, input vlmul_e lmul, input logic [31:0] avl);
        vec_cmd_t c;
        c        = '0;
        c.op     = VSETVL;
        c.sew    = sew;
        c.lmul   = lmul;
        c.scalar = avl;
        enqueue(c);
    endtask

    task automatic arith_row(input vec_op_e op, input logic [4:0] vd, input logic [4:0] vs2,
                             input logic [4:0] vs1);
        vec_cmd_t c;
        c     = '0;
        c.op  = op;
        c.vd  = vd;
        c.vs2 = vs2;
        c.vs1 = vs1;
        enqueue(c);
    endtask

    task automatic scalar_add_row(input logic [4:0] vd, input logic [4:0] vs2,
                                  input logic [31:0] scalar);
        vec_cmd_t c;
        c        = '0;
        c.op     = VADD_VX;
        c.vd     = vd;
        c.vs2    = vs2;
        c.scalar = scalar;
        enqueue(c);
    endtask

    task automatic memory_row(input vec_op_e op, input logic [4:0] vd, input logic [31:0] base);
        vec_cmd_t c;
        c        = '0;
        c.op     = op;
        c.vd     = vd;
        c.scalar = base;
        enqueue(c);
    endtask

    task automatic move_row(input logic [4:0] vs2);
        vec_cmd_t c;
        c     = '0;
        c.op  = VMV_X_S;
        c.vs2 = vs2;
        enqueue(c);
    endtask

    task automatic build_table();
        // Granted vl below and above VLMAX for every sew/lmul pair
        setvl_row(EW8,  LMUL_1, 5);
        setvl_row(EW8,  LMUL_1, 20);
        setvl_row(EW8,  LMUL_2, 16);
        setvl_row(EW8,  LMUL_2, 9);
        setvl_row(EW8,  LMUL_2, 17);
        setvl_row(EW8,  LMUL_4, 40);
        setvl_row(EW8,  LMUL_4, 31);
        setvl_row(EW16, LMUL_1, 4);
        setvl_row(EW16, LMUL_1, 2);
        setvl_row(EW16, LMUL_1, 5);
        setvl_row(EW16, LMUL_2, 3);
        setvl_row(EW16, LMUL_2, 100);
        setvl_row(EW16, LMUL_4, 15);
        setvl_row(EW16, LMUL_4, 64);
        setvl_row(EW32, LMUL_1, 6);
        setvl_row(EW32, LMUL_1, 1);
        setvl_row(EW32, LMUL_2, 1);
        setvl_row(EW32, LMUL_2, 5);
        setvl_row(EW32, LMUL_4, 7);
        setvl_row(EW32, LMUL_4, 32'hFFFF_FFFF);
        // Byte lanes, single registers
        setvl_row(EW8, LMUL_1, 8);
        memory_row(VLE, 1, 'h00);
        memory_row(VLE, 2, 'h08);
        move_row(1);
        arith_row(VADD_VV, 3, 1, 2);
        memory_row(VSE, 3, 'h80);
        arith_row(VSUB_VV, 4, 1, 2);
        memory_row(VSE, 4, 'h88);
        // Halfword lanes over groups of two
        setvl_row(EW16, LMUL_2, 8);
        memory_row(VLE, 8, 'h10);
        memory_row(VLE, 10, 'h20);
        move_row(8);
        arith_row(VAND_VV, 12, 8, 10);
        arith_row(VOR_VV, 14, 8, 10);
        arith_row(VXOR_VV, 16, 8, 10);
        memory_row(VSE, 12, 'h90);
        memory_row(VSE, 14, 'hA0);
        memory_row(VSE, 16, 'hB0);
        // Word lanes over groups of four
        setvl_row(EW32, LMUL_4, 8);
        memory_row(VLE, 20, 'h40);
        memory_row(VLE, 24, 'h60);
        move_row(24);
        arith_row(VADD_VV, 28, 20, 24);
        memory_row(VSE, 28, 'hC0);
        arith_row(VSUB_VV, 28, 24, 20);
        memory_row(VSE, 28, 'hE0);
        // Scalar spread over halfword lanes
        setvl_row(EW16, LMUL_1, 4);
        scalar_add_row(5, 2, 32'h1234_F00D);
        memory_row(VSE, 5, 'h00);
        move_row(5);
        // Tail elements, in vd and in memory
        setvl_row(EW8, LMUL_2, 16);
        memory_row(VLE, 6, 'h10);
        setvl_row(EW8, LMUL_2, 11);
        arith_row(VADD_VV, 6, 8, 10);
        memory_row(VSE, 6, 'h38);
        setvl_row(EW8, LMUL_2, 16);
        memory_row(VSE, 6, 'h20);
        setvl_row(EW32, LMUL_2, 3);
        scalar_add_row(30, 20, 32'h8000_0001);
        memory_row(VSE, 30, 'h50);
    endtask

    // Polls cmd_ack after each edge until it reaches the wanted level
    task automatic wait_for_ack(input logic level, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            #1;
            ok = (cmd_ack === level);
            cycles++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        reset_n        = 1'b0;
        cmd_req        = 1'b0;
        cmd            = '0;
        mem_rdata      = '0;
        value_errors   = 0;
        timeout_errors = 0;
        ref_ewb        = 1;
        ref_nregs      = 1;
        ref_vl         = 0;
        seed           = 29;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = $random(seed);
            ref_mem[i] = mem[i];
        end
        for (int i = 0; i < `VEC_NREGS; i++) begin
            ref_regs[i] = '0;
        end
        build_table();

        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;

        for (int i = 0; i < cmd_list.size(); i++) begin
            cmd     = cmd_list[i];
            cmd_req = 1'b1;
            wait_for_ack(1'b1, handshake_ok);
            if (!handshake_ok) begin
                $display("Timed out waiting for cmd_ack_o to rise on command %0d", i);
                timeout_errors++;
                break;
            end
            assert (res === exp_list[i]) else begin
                value_errors++;
                $display("error %0t: command %0d (%s) returned %h, expected %h",
                         $time, i, cmd.op.name(), res, exp_list[i]);
            end
            cmd_req = 1'b0;
            wait_for_ack(1'b0, handshake_ok);
            if (!handshake_ok) begin
                $display("Timed out waiting for cmd_ack_o to fall on command %0d", i);
                timeout_errors++;
                break;
            end
        end

        // Final memory image against the model
        if (timeout_errors == 0) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                assert (mem[i] === ref_mem[i]) else begin
                    value_errors++;
                    $display("error %0t: memory word at 0x%02h is %h, expected %h",
                             $time, i * 4, mem[i], ref_mem[i]);
                end
            end
        end

        $display("value errors: %0d, timeout errors: %0d", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/vec_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_unit_assert import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_req_i,
    input  vec_cmd_t                cmd_i,
    input  logic                    cmd_ack_o,
    input  logic                    mem_rd_en_o,
    input  logic [`VEC_XLEN/8-1:0]  mem_we_o
);

    // Ack drops only once the request has been withdrawn
    ack_release_a: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(cmd_ack_o) |-> !$past(cmd_req_i))
        else $error("cmd_ack_o fell while cmd_req_i was still high");

    // One memory access kind per cycle
    mem_exclusive_a: assert property (@(posedge clk) disable iff (!reset_n)
        !(mem_rd_en_o && (|mem_we_o)))
        else $error("memory read and write enables active in the same cycle");

    // Command held steady until it is acknowledged
    cmd_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
        (cmd_req_i && $past(cmd_req_i) && !$past(cmd_ack_o)) |-> $stable(cmd_i))
        else $error("cmd_i changed while a request was pending");

endmodule

`default_nettype wire

// ==== verilog/vec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_unit import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_req_i,
    input  vec_cmd_t                cmd_i,
    output logic                    cmd_ack_o,
    output logic [`VEC_XLEN-1:0]    res_o,
    output logic [`VEC_XLEN-1:0]    mem_addr_o,
    output logic                    mem_rd_en_o,
    output logic [`VEC_XLEN/8-1:0]  mem_we_o,
    output logic [`VEC_XLEN-1:0]    mem_wdata_o,
    input  logic [`VEC_XLEN-1:0]    mem_rdata_i
);

    logic                       csr_wr, ld_valid, lsu_done, lsu_next_reg, lsu_start, lsu_store;
    vew_e                       sew;
    vlmul_e                     lmul;
    logic [`VEC_VL_W-1:0]       vl, vlmax;
    vreg_addr_t                 vs1_addr, vs2_addr;
    logic [`VEC_VLEN-1:0]       vs1_data, vs2_data, alu_result, ld_data;
    vec_wr_t                    wr;
    logic [`VEC_GRP_W-1:0]      lsu_nregs;
    logic [`VEC_VLENB-1:0]      byte_en;

    vec_csr vec_csr_inst (
        .clk(clk), .reset_n(reset_n), .csr_wr_i(csr_wr),
        .sew_i(cmd_i.sew), .lmul_i(cmd_i.lmul), .avl_i(cmd_i.scalar),
        .sew_o(sew), .lmul_o(lmul), .vl_o(vl), .vlmax_o(vlmax)
    );

    vec_sequencer vec_sequencer_inst (
        .clk(clk), .reset_n(reset_n), .cmd_req_i(cmd_req_i), .cmd_i(cmd_i),
        .vl_i(vl), .vlmax_i(vlmax), .sew_i(sew), .lmul_i(lmul),
        .vs1_data_i(vs1_data), .vs2_data_i(vs2_data), .alu_result_i(alu_result),
        .ld_data_i(ld_data), .ld_valid_i(ld_valid), .lsu_done_i(lsu_done),
        .lsu_next_reg_i(lsu_next_reg), .cmd_ack_o(cmd_ack_o), .res_o(res_o),
        .csr_wr_o(csr_wr), .vs1_addr_o(vs1_addr), .vs2_addr_o(vs2_addr), .wr_o(wr),
        .lsu_start_o(lsu_start), .lsu_store_o(lsu_store), .lsu_nregs_o(lsu_nregs),
        .byte_en_o(byte_en)
    );

    vec_regbank vec_regbank_inst (
        .clk(clk), .vs1_addr_i(vs1_addr), .vs2_addr_i(vs2_addr), .wr_i(wr),
        .vs1_data_o(vs1_data), .vs2_data_o(vs2_data)
    );

    // vs2 is the minuend of a subtract
    vec_alu vec_alu_inst (
        .op_i(cmd_i.op), .sew_i(sew), .a_i(vs2_data), .b_i(vs1_data),
        .scalar_i(cmd_i.scalar), .result_o(alu_result)
    );

    vec_lsu vec_lsu_inst (
        .clk(clk), .reset_n(reset_n), .start_i(lsu_start), .store_i(lsu_store),
        .nregs_i(lsu_nregs), .base_i(cmd_i.scalar), .byte_en_i(byte_en),
        .st_data_i(vs1_data), .ld_data_o(ld_data), .ld_valid_o(ld_valid),
        .done_o(lsu_done), .next_reg_o(lsu_next_reg), .mem_addr_o(mem_addr_o),
        .mem_rd_en_o(mem_rd_en_o), .mem_we_o(mem_we_o), .mem_wdata_o(mem_wdata_o),
        .mem_rdata_i(mem_rdata_i)
    );

endmodule

`default_nettype wire

// ==== verilog/vec_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_lsu (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    start_i,
    input  logic                    store_i,
    input  logic [`VEC_GRP_W-1:0]   nregs_i,
    input  logic [`VEC_XLEN-1:0]    base_i,
    input  logic [`VEC_VLENB-1:0]   byte_en_i,
    input  logic [`VEC_VLEN-1:0]    st_data_i,
    output logic [`VEC_VLEN-1:0]    ld_data_o,
    output logic                    ld_valid_o,
    output logic                    done_o,
    output logic                    next_reg_o,
    output logic [`VEC_XLEN-1:0]    mem_addr_o,
    output logic                    mem_rd_en_o,
    output logic [`VEC_XLEN/8-1:0]  mem_we_o,
    output logic [`VEC_XLEN-1:0]    mem_wdata_o,
    input  logic [`VEC_XLEN-1:0]    mem_rdata_i
);

    logic                       busy_q, store_q, word_hi, reg_last, mem_phase;
    logic [1:0]                 phase_q;
    logic [`VEC_GRP_W-1:0]      reg_q, nregs_q;
    logic [`VEC_XLEN-1:0]       base_q, lo_q;

    ////////////////////////////////////////////////////////////
    // Per register phases 0 and 1 move a word, phase 2 finishes it

    assign word_hi   = (phase_q == 2'd1);
    assign mem_phase = busy_q && (phase_q != 2'd2);
    assign reg_last  = (reg_q == nregs_q - 1'b1);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            busy_q  <= 1'b0;
            phase_q <= '0;
            reg_q   <= '0;
        end else if (start_i) begin
            busy_q  <= 1'b1;
            phase_q <= '0;
            reg_q   <= '0;
        end else if (busy_q) begin
            if (phase_q == 2'd2) begin
                phase_q <= '0;
                reg_q   <= reg_q + 1'b1;
                busy_q  <= !reg_last;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            store_q <= store_i;
            nregs_q <= nregs_i;
            base_q  <= base_i;
        end
        // Low word returns one cycle after its read
        if (phase_q == 2'd1) begin
            lo_q <= mem_rdata_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Memory port

    // Register r sits at base + 8r, low word first
    assign mem_addr_o  = base_q + `VEC_XLEN'({reg_q, word_hi, 2'b00});
    assign mem_rd_en_o = mem_phase && !store_q;
    assign mem_we_o    = (mem_phase && store_q) ? byte_en_i[{word_hi, 2'b00} +: 4] : '0;
    assign mem_wdata_o = st_data_i[{word_hi, 5'b00000} +: `VEC_XLEN];

    assign ld_data_o  = {mem_rdata_i, lo_q};
    assign ld_valid_o = busy_q && !store_q && (phase_q == 2'd2);
    assign next_reg_o = busy_q && (phase_q == 2'd2);
    assign done_o     = next_reg_o && reg_last;

endmodule

`default_nettype wire

// ==== verilog/vec_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_alu import vec_pkg::*; (
    input  vec_op_e                 op_i,
    input  vew_e                    sew_i,
    input  logic [`VEC_VLEN-1:0]    a_i,
    input  logic [`VEC_VLEN-1:0]    b_i,
    input  logic [`VEC_XLEN-1:0]    scalar_i,
    output logic [`VEC_VLEN-1:0]    result_o
);

    logic [`VEC_VLEN-1:0] scalar_rep, opb;

    // Carries and borrows stay inside each lane
    function automatic logic [`VEC_VLEN-1:0] lane_arith(
        input logic [`VEC_VLEN-1:0] x,
        input logic [`VEC_VLEN-1:0] y,
        input logic                 sub,
        input vew_e                 sew
    );
        logic [`VEC_VLEN-1:0] r;
        r = '0;
        case (sew)
            EW8: begin
                for (int i = 0; i < `VEC_VLEN/8; i++) begin
                    r[8*i +: 8] = sub ? x[8*i +: 8] - y[8*i +: 8] : x[8*i +: 8] + y[8*i +: 8];
                end
            end
            EW16: begin
                for (int i = 0; i < `VEC_VLEN/16; i++) begin
                    r[16*i +: 16] = sub ? x[16*i +: 16] - y[16*i +: 16]
                                        : x[16*i +: 16] + y[16*i +: 16];
                end
            end
            default: begin
                for (int i = 0; i < `VEC_VLEN/32; i++) begin
                    r[32*i +: 32] = sub ? x[32*i +: 32] - y[32*i +: 32]
                                        : x[32*i +: 32] + y[32*i +: 32];
                end
            end
        endcase
        return r;
    endfunction

    // Scalar copied into every lane of the current width
    always_comb begin
        case (sew_i)
            EW8:     scalar_rep = {(`VEC_VLEN/8){scalar_i[7:0]}};
            EW16:    scalar_rep = {(`VEC_VLEN/16){scalar_i[15:0]}};
            default: scalar_rep = {(`VEC_VLEN/32){scalar_i[31:0]}};
        endcase
    end

    assign opb = (op_i == VADD_VX) ? scalar_rep : b_i;

    always_comb begin
        case (op_i)
            VADD_VV, VADD_VX: result_o = lane_arith(a_i, opb, 1'b0, sew_i);
            VSUB_VV:          result_o = lane_arith(a_i, opb, 1'b1, sew_i);
            VAND_VV:          result_o = a_i & opb;
            VOR_VV:           result_o = a_i | opb;
            VXOR_VV:          result_o = a_i ^ opb;
            default:          result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/vec_regbank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_regbank import vec_pkg::*; (
    input  logic                    clk,
    input  vreg_addr_t              vs1_addr_i,
    input  vreg_addr_t              vs2_addr_i,
    input  vec_wr_t                 wr_i,
    output logic [`VEC_VLEN-1:0]    vs1_data_o,
    output logic [`VEC_VLEN-1:0]    vs2_data_o
);

    logic [`VEC_VLEN-1:0] regs_q [`VEC_NREGS];

    // Byte lanes outside byte_en keep their old contents
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            for (int b = 0; b < `VEC_VLENB; b++) begin
                if (wr_i.byte_en[b]) begin
                    regs_q[wr_i.addr][8*b +: 8] <= wr_i.data[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read ports
    assign vs1_data_o = regs_q[vs1_addr_i];
    assign vs2_data_o = regs_q[vs2_addr_i];

endmodule

`default_nettype wire

// ==== verilog/vec_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_sequencer import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    cmd_req_i,
    input  vec_cmd_t                cmd_i,
    input  logic [`VEC_VL_W-1:0]    vl_i,
    input  logic [`VEC_VL_W-1:0]    vlmax_i,
    input  vew_e                    sew_i,
    input  vlmul_e                  lmul_i,
    input  logic [`VEC_VLEN-1:0]    vs1_data_i,
    input  logic [`VEC_VLEN-1:0]    vs2_data_i,
    input  logic [`VEC_VLEN-1:0]    alu_result_i,
    input  logic [`VEC_VLEN-1:0]    ld_data_i,
    input  logic                    ld_valid_i,
    input  logic                    lsu_done_i,
    input  logic                    lsu_next_reg_i,
    output logic                    cmd_ack_o,
    output logic [`VEC_XLEN-1:0]    res_o,
    output logic                    csr_wr_o,
    output vreg_addr_t              vs1_addr_o,
    output vreg_addr_t              vs2_addr_o,
    output vec_wr_t                 wr_o,
    output logic                    lsu_start_o,
    output logic                    lsu_store_o,
    output logic [`VEC_GRP_W-1:0]   lsu_nregs_o,
    output logic [`VEC_VLENB-1:0]   byte_en_o
);

    typedef enum logic [1:0] {S_IDLE, S_EXEC, S_ACK, S_REL} seq_state_e;

    seq_state_e                 state_q, state_d;
    vec_cmd_t                   cmd_q;
    logic [`VEC_GRP_W-2:0]      reg_cnt_q;
    logic [`VEC_VL_W-1:0]       remain_q, epr;
    logic [`VEC_GRP_W-1:0]      nregs;
    logic                       start_q, is_alu, is_mem, last_reg, advance;
    logic [`VEC_XLEN-1:0]       elem0;

    assign is_alu   = cmd_q.op inside {VADD_VV, VSUB_VV, VAND_VV, VOR_VV, VXOR_VV, VADD_VX};
    assign is_mem   = cmd_q.op inside {VLE, VSE};
    assign epr      = `VEC_VL_W'(`VEC_VLENB >> sew_i);
    assign nregs    = {{(`VEC_GRP_W-1){1'b0}}, 1'b1} << lmul_i;
    assign last_reg = ({1'b0, reg_cnt_q} == nregs - 1'b1);
    // ALU steps every cycle, the LSU steps once per assembled register
    assign advance  = (state_q == S_EXEC) && (is_alu || (is_mem && lsu_next_reg_i));

    ////////////////////////////////////////////////////////////
    // Command FSM

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (cmd_req_i) begin
                    state_d = S_EXEC;
                end
            end
            S_EXEC: begin
                if ((is_alu && last_reg) || (is_mem && lsu_done_i) || (!is_alu && !is_mem)) begin
                    state_d = S_ACK;
                end
            end
            S_ACK: begin
                if (!cmd_req_i) begin
                    state_d = S_REL;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q   <= S_IDLE;
            start_q   <= 1'b0;
            reg_cnt_q <= '0;
            remain_q  <= '0;
        end else begin
            state_q <= state_d;
            start_q <= (state_q == S_IDLE) && cmd_req_i;
            if (state_q == S_IDLE) begin
                reg_cnt_q <= '0;
                remain_q  <= (vl_i < vlmax_i) ? vl_i : vlmax_i;
            end else if (advance) begin
                reg_cnt_q <= reg_cnt_q + 1'b1;
                remain_q  <= (remain_q > epr) ? remain_q - epr : '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && cmd_req_i) begin
            cmd_q <= cmd_i;
        end
    end

    ////////////////////////////////////////////////////////////
    // Tail masking and register write port

    always_comb begin
        for (int b = 0; b < `VEC_VLENB; b++) begin
            byte_en_o[b] = remain_q > `VEC_VL_W'(b >> sew_i);
        end
    end

    always_comb begin
        wr_o.we      = (state_q == S_EXEC) && (is_alu || ld_valid_i);
        wr_o.addr    = cmd_q.vd + vreg_addr_t'(reg_cnt_q);
        wr_o.byte_en = byte_en_o;
        wr_o.data    = is_alu ? alu_result_i : ld_data_i;
    end

    // Stores read the group being written out through port 1
    assign vs1_addr_o = ((cmd_q.op == VSE) ? cmd_q.vd : cmd_q.vs1) + vreg_addr_t'(reg_cnt_q);
    assign vs2_addr_o = cmd_q.vs2 + vreg_addr_t'(reg_cnt_q);

    assign csr_wr_o    = (state_q == S_EXEC) && (cmd_q.op == VSETVL);
    assign lsu_start_o = start_q && is_mem;
    assign lsu_store_o = (cmd_q.op == VSE);
    assign lsu_nregs_o = nregs;
    assign cmd_ack_o   = (state_q == S_ACK);

    ////////////////////////////////////////////////////////////
    // Scalar result

    always_comb begin
        elem0 = '0;
        case (sew_i)
            EW8:     elem0[7:0]  = vs2_data_i[7:0];
            EW16:    elem0[15:0] = vs2_data_i[15:0];
            default: elem0       = vs2_data_i[`VEC_XLEN-1:0];
        endcase
        case (cmd_q.op)
            VSETVL:  res_o = `VEC_XLEN'(vl_i);
            VMV_X_S: res_o = elem0;
            default: res_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/vec_csr.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "vec_params.svh"

module vec_csr import vec_pkg::*; (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    csr_wr_i,
    input  vew_e                    sew_i,
    input  vlmul_e                  lmul_i,
    input  logic [`VEC_XLEN-1:0]    avl_i,
    output vew_e                    sew_o,
    output vlmul_e                  lmul_o,
    output logic [`VEC_VL_W-1:0]    vl_o,
    output logic [`VEC_VL_W-1:0]    vlmax_o
);

    vew_e                   sew_q;
    vlmul_e                 lmul_q;
    logic [`VEC_VL_W-1:0]   vl_q;
    logic [`VEC_VL_W-1:0]   vlmax_new;

    // Elements per register times registers per group
    function automatic logic [`VEC_VL_W-1:0] calc_vlmax(input vew_e sew, input vlmul_e lmul);
        logic [`VEC_VL_W-1:0] epr;
        epr = `VEC_VL_W'(`VEC_VLENB >> sew);
        return epr << lmul;
    endfunction

    assign vlmax_new = calc_vlmax(sew_i, lmul_i);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sew_q  <= EW8;
            lmul_q <= LMUL_1;
            vl_q   <= '0;
        end else if (csr_wr_i) begin
            sew_q  <= sew_i;
            lmul_q <= lmul_i;
            // Granted length never exceeds the new VLMAX
            vl_q   <= (avl_i < `VEC_XLEN'(vlmax_new)) ? avl_i[`VEC_VL_W-1:0] : vlmax_new;
        end
    end

    assign sew_o   = sew_q;
    assign lmul_o  = lmul_q;
    assign vl_o    = vl_q;
    assign vlmax_o = calc_vlmax(sew_q, lmul_q);

endmodule

`default_nettype wire

// ==== verilog/vec_pkg.sv ====
`default_nettype none

`include "vec_params.svh"

package vec_pkg;

    typedef enum logic [3:0] {
        VSETVL,
        VADD_VV,
        VSUB_VV,
        VAND_VV,
        VOR_VV,
        VXOR_VV,
        VADD_VX,
        VLE,
        VSE,
        VMV_X_S
    } vec_op_e;

    typedef enum logic [1:0] {
        EW8,
        EW16,
        EW32
    } vew_e;

    typedef enum logic [1:0] {
        LMUL_1,
        LMUL_2,
        LMUL_4
    } vlmul_e;

    typedef logic [$clog2(`VEC_NREGS)-1:0] vreg_addr_t;

    // Scalar is avl for VSETVL, base address for loads and stores
    typedef struct packed {
        vec_op_e                op;
        vreg_addr_t             vd;
        vreg_addr_t             vs1;
        vreg_addr_t             vs2;
        vew_e                   sew;
        vlmul_e                 lmul;
        logic [`VEC_XLEN-1:0]   scalar;
    } vec_cmd_t;

    typedef struct packed {
        logic                   we;
        vreg_addr_t             addr;
        logic [`VEC_VLENB-1:0]  byte_en;
        logic [`VEC_VLEN-1:0]   data;
    } vec_wr_t;

endpackage

`default_nettype wire

// ==== include/vec_params.svh ====
`ifndef VEC_PARAMS_SVH
`define VEC_PARAMS_SVH

// Vector register geometry
`define VEC_VLEN      64
`define VEC_VLENB     8
`define VEC_NREGS     32

// Scalar operand and memory word width
`define VEC_XLEN      32

// Largest register group
`define VEC_MAX_LMUL  4

// Width of vl and vlmax, and of a register count within a group
`define VEC_VL_W      ($clog2(`VEC_VLENB * `VEC_MAX_LMUL) + 1)
`define VEC_GRP_W     ($clog2(`VEC_MAX_LMUL) + 1)

`endif
